// ==== verilog/xbar_settings.svh ====
`ifndef XBAR_SETTINGS_SVH
`define XBAR_SETTINGS_SVH

// Number of push flows feeding the crossbar
`define NUM_PUSH 4

// Number of pop flows leaving the crossbar
`define NUM_POP 4

// Width of one flow's data word
`define DATA_WIDTH 16

// Destination ID width is log2 of the pop count but never below one bit
`define DEST_WIDTH ((`NUM_POP > 1) ? $clog2(`NUM_POP) : 1)

`endif

// ==== verilog/xbarPkg.sv ====
`default_nettype none

`include "xbar_settings.svh"

package xbarPkg;

  // --------------------
  // Payload types
  // --------------------

  // One data word as carried by a push or pop flow
  typedef logic [`DATA_WIDTH-1:0] dataT;

  // Binary number of the pop flow a push is aimed at
  typedef logic [`DEST_WIDTH-1:0] destIdT;

  // --------------------
  // Flow masks
  // --------------------

  // One bit per push flow, used for requests, grants and push handshakes
  typedef logic [`NUM_PUSH-1:0] pushMaskT;

  // One bit per pop flow, used for pop handshakes and priority updates
  typedef logic [`NUM_POP-1:0] popMaskT;

endpackage

`default_nettype wire

// ==== verilog/rrArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "xbar_settings.svh"

// Round-robin arbiter serving a single pop flow
module rrArbiter (
  input  logic             clk,
  input  logic             reset,
  input  xbarPkg::pushMaskT request,
  input  logic             enablePriorityUpdate,
  output xbarPkg::pushMaskT grant
);

  // One-hot pointer whose set bit marks the highest-priority source
  xbarPkg::pushMaskT priorityPtr;

  // Every source at or above the pointer index
  xbarPkg::pushMaskT thermoMask;

  // Requests that sit at or above the pointer
  xbarPkg::pushMaskT maskedRequest;

  // Pointer value for the cycle after an accepted transfer
  xbarPkg::pushMaskT nextPtr;

  // --------------------
  // Grant selection
  // --------------------

  // Subtracting one from a one-hot value sets every bit below it,
  // so inverting that keeps the pointer bit and all bits above it
  assign thermoMask    = ~(priorityPtr - xbarPkg::pushMaskT'(1));
  assign maskedRequest = request & thermoMask;

  // Search from the pointer upward first and wrap to bit 0 when nothing is there
  always_comb begin
    if (|maskedRequest) begin
      // Lowest set bit of the masked requests
      grant = maskedRequest & (~maskedRequest + xbarPkg::pushMaskT'(1));
    end else begin
      // The wrapped search takes the lowest set bit of all requests
      grant = request & (~request + xbarPkg::pushMaskT'(1));
    end
  end

  // --------------------
  // Pointer update
  // --------------------

  // The winner drops to lowest priority, so the pointer lands one index above it
  assign nextPtr = (grant << 1) | (grant >> (`NUM_PUSH - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      // Source 0 starts out as the highest priority
      priorityPtr <= xbarPkg::pushMaskT'(1);
    end else if (enablePriorityUpdate && (|grant)) begin
      priorityPtr <= nextPtr;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/xbarCore.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "xbar_settings.svh"

// Combinational datapath of the crossbar
//
// Requests are decoded from the destination IDs and handed to one arbiter
// per pop flow. The grants come back the same cycle and steer both the pop
// data mux and the push ready signals, so a push that wins its output moves
// straight through with no storage on the way
module xbarCore (
  input  xbarPkg::pushMaskT                  pushValid,
  input  xbarPkg::dataT    [`NUM_PUSH-1:0]   pushData,
  input  xbarPkg::destIdT  [`NUM_PUSH-1:0]   pushDestId,
  output xbarPkg::pushMaskT                  pushReady,

  input  xbarPkg::popMaskT                   popReady,
  output xbarPkg::popMaskT                   popValid,
  output xbarPkg::dataT    [`NUM_POP-1:0]    popData,

  output xbarPkg::pushMaskT [`NUM_POP-1:0]   request,
  input  xbarPkg::pushMaskT [`NUM_POP-1:0]   grant,
  output xbarPkg::popMaskT                   enablePriorityUpdate
);

  // --------------------
  // Request matrix
  // --------------------

  // Row j collects every valid push whose destination is pop flow j.
  // A source only ever appears in one row because its ID picks exactly one
  always_comb begin
    for (int j = 0; j < `NUM_POP; j++) begin
      for (int i = 0; i < `NUM_PUSH; i++) begin
        request[j][i] = pushValid[i] && (pushDestId[i] == xbarPkg::destIdT'(j));
      end
    end
  end

  // --------------------
  // Pop side
  // --------------------

  // An output has something to offer as soon as any source is aimed at it.
  // The arbiter always grants one of those, so valid never waits on the grant
  always_comb begin
    for (int j = 0; j < `NUM_POP; j++) begin
      popValid[j] = |request[j];
    end
  end

  // AND-OR mux over the grant row.
  // Grants are one-hot or zero, so at most one term is non-zero per output
  always_comb begin
    for (int j = 0; j < `NUM_POP; j++) begin
      popData[j] = '0;
      for (int i = 0; i < `NUM_PUSH; i++) begin
        popData[j] |= {`DATA_WIDTH{grant[j][i]}} & pushData[i];
      end
    end
  end

  // --------------------
  // Push side
  // --------------------

  // A source is ready when it holds the grant at some output and that output
  // can take the word this cycle.
  // Grants only exist where the source requested, which already ties
  // the output to the source's destination ID
  always_comb begin
    for (int i = 0; i < `NUM_PUSH; i++) begin
      pushReady[i] = 1'b0;
      for (int j = 0; j < `NUM_POP; j++) begin
        pushReady[i] |= grant[j][i] & popReady[j];
      end
    end
  end

  // --------------------
  // Arbiter feedback
  // --------------------

  // Priority only rotates once the pop handshake completes.
  // While popReady is held low the pointer stays put, the request
  // set cannot change under the handshake rule, and so the grant and the
  // pop data stay stable until the transfer goes through
  assign enablePriorityUpdate = popValid & popReady;

endmodule

`default_nettype wire

// ==== verilog/flowXbarRr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "xbar_settings.svh"

// Flow-controlled crossbar with round-robin arbitration per output
//
// Every push flow names its output with a binary destination ID. Pushes to
// distinct outputs all pass in the same cycle, and pushes that collide on one
// output take turns in round-robin order starting from source 0
module flowXbarRr (
  input  logic                               clk,
  input  logic                               reset,

  input  xbarPkg::pushMaskT                  pushValid,
  input  xbarPkg::dataT    [`NUM_PUSH-1:0]   pushData,
  input  xbarPkg::destIdT  [`NUM_PUSH-1:0]   pushDestId,
  output xbarPkg::pushMaskT                  pushReady,

  input  xbarPkg::popMaskT                   popReady,
  output xbarPkg::popMaskT                   popValid,
  output xbarPkg::dataT    [`NUM_POP-1:0]    popData
);

  // One request row and one grant row per pop flow
  xbarPkg::pushMaskT [`NUM_POP-1:0] request;
  xbarPkg::pushMaskT [`NUM_POP-1:0] grant;

  // Strobes that move each arbiter's pointer after a completed pop
  xbarPkg::popMaskT enablePriorityUpdate;

  // --------------------
  // Datapath
  // --------------------

  xbarCore i_xbarCore (
    .pushValid            (pushValid),
    .pushData             (pushData),
    .pushDestId           (pushDestId),
    .pushReady            (pushReady),
    .popReady             (popReady),
    .popValid             (popValid),
    .popData              (popData),
    .request              (request),
    .grant                (grant),
    .enablePriorityUpdate (enablePriorityUpdate)
  );

  // --------------------
  // Arbiters
  // --------------------

  // Each output keeps its own pointer, so fairness is tracked per destination
  for (genvar j = 0; j < `NUM_POP; j++) begin : genArbiters
    rrArbiter i_rrArbiter (
      .clk                  (clk),
      .reset                (reset),
      .request              (request[j]),
      .enablePriorityUpdate (enablePriorityUpdate[j]),
      .grant                (grant[j])
    );
  end

endmodule

`default_nettype wire

// ==== bench/flowXbarRr_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "xbar_settings.svh"

// Handshake checks on the crossbar that are bound into every flowXbarRr instance
module flowXbarRr_assert (
  input logic                               clk,
  input logic                               reset,
  input xbarPkg::pushMaskT                  pushValid,
  input xbarPkg::destIdT  [`NUM_PUSH-1:0]   pushDestId,
  input xbarPkg::pushMaskT                  pushReady,
  input xbarPkg::popMaskT                   popReady,
  input xbarPkg::popMaskT                   popValid,
  input xbarPkg::dataT    [`NUM_POP-1:0]    popData,
  input xbarPkg::pushMaskT [`NUM_POP-1:0]   request
);

  // Accepted pushes sorted by the output they land on
  xbarPkg::pushMaskT [`NUM_POP-1:0] acceptedAt;

  always_comb begin
    for (int j = 0; j < `NUM_POP; j++) begin
      for (int i = 0; i < `NUM_PUSH; i++) begin
        acceptedAt[j][i] = pushValid[i] && pushReady[i] &&
                           (pushDestId[i] == xbarPkg::destIdT'(j));
      end
    end
  end

  for (genvar j = 0; j < `NUM_POP; j++) begin : genPopChecks
    // A stalled output keeps its word on offer
    holdValid: assert property (@(posedge clk) disable iff (reset)
      (popValid[j] && !popReady[j]) |=> popValid[j])
      else $error("pop flow %0d dropped valid while stalled", j);

    // With the same requesters the grant cannot move, so neither can the data
    holdData: assert property (@(posedge clk) disable iff (reset)
      (popValid[j] && !popReady[j]) |=> (request[j] != $past(request[j])) || $stable(popData[j]))
      else $error("pop flow %0d changed data while stalled", j);

    oneAccept: assert property (@(posedge clk) disable iff (reset) $onehot0(acceptedAt[j]))
      else $error("more than one push accepted for pop flow %0d", j);
  end

  readyNeedsValid: assert property (@(posedge clk) disable iff (reset)
    (pushReady & ~pushValid) == '0)
    else $error("push ready raised on an idle push flow");

endmodule

bind flowXbarRr flowXbarRr_assert i_flowXbarRr_assert (
  .clk        (clk),
  .reset      (reset),
  .pushValid  (pushValid),
  .pushDestId (pushDestId),
  .pushReady  (pushReady),
  .popReady   (popReady),
  .popValid   (popValid),
  .popData    (popData),
  .request    (request)
);

`default_nettype wire

// ==== bench/flowXbarRr_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "xbar_settings.svh"

module flowXbarRr_tb;

  // Size of the stimulus memory and the bounds on every wait
  localparam int stimDepth     = 64;
  localparam int acceptTimeout = 200;
  localparam int phaseLimit    = 2000;

  logic                              clk;
  logic                              reset;
  xbarPkg::pushMaskT                 pushValid;
  xbarPkg::dataT   [`NUM_PUSH-1:0]   pushData;
  xbarPkg::destIdT [`NUM_PUSH-1:0]   pushDestId;
  xbarPkg::pushMaskT                 pushReady;
  xbarPkg::popMaskT                  popReady;
  xbarPkg::popMaskT                  popValid;
  xbarPkg::dataT   [`NUM_POP-1:0]    popData;

  // Raw words from the stimulus file
  logic [31:0] stimMem [0:stimDepth-1];

  // Expected words in one queue per source and destination pair
  xbarPkg::dataT expQ [`NUM_PUSH*`NUM_POP][$];

  // Last sequence count seen per pair, and a model pointer per output
  int lastSeq [`NUM_PUSH*`NUM_POP];
  int modelPtr [`NUM_POP];

  int currentPhase = 0;
  int pushCount = 0;
  int popCount = 0;
  int totalEntries = 0;
  logic flowsDone;
  logic [31:0] lcgState;

  flowXbarRr i_flowXbarRr (
    .clk        (clk),
    .reset      (reset),
    .pushValid  (pushValid),
    .pushData   (pushData),
    .pushDestId (pushDestId),
    .pushReady  (pushReady),
    .popReady   (popReady),
    .popValid   (popValid),
    .popData    (popData)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------
  // Helpers
  // --------------------

  task automatic stopRun();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic failRun(input string msg);
    $display("%s", msg);
    stopRun();
  endtask

  task automatic checkData(input xbarPkg::dataT expected, input xbarPkg::dataT actual,
                           input string what);
    if (actual !== expected) begin
      $display("ERR %0t: %s expected %h got %h", $time, what, expected, actual);
      stopRun();
    end
  endtask

  task automatic checkGrant(input xbarPkg::pushMaskT expected, input xbarPkg::pushMaskT actual,
                            input string what);
    if (actual !== expected) begin
      $display("ERR %0t: %s expected %b got %b", $time, what, expected, actual);
      stopRun();
    end
  endtask

  task automatic checkValid(input xbarPkg::popMaskT expected, input xbarPkg::popMaskT actual,
                            input string what);
    if (actual !== expected) begin
      $display("ERR %0t: %s expected %b got %b", $time, what, expected, actual);
      stopRun();
    end
  endtask

  task automatic checkCount(input int expected, input int actual, input string what);
    if (actual != expected) begin
      $display("ERR %0t: %s expected %0d got %0d", $time, what, expected, actual);
      stopRun();
    end
  endtask

  // Linear congruential generator for pop back-pressure
  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // Round-robin model that picks the first requester at or after the pointer
  function automatic xbarPkg::pushMaskT expectedGrant(input xbarPkg::pushMaskT req,
                                                      input int ptr);
    xbarPkg::pushMaskT result;
    int idx;
    bit found;
    result = '0;
    found = 1'b0;
    for (int k = 0; k < `NUM_PUSH; k++) begin
      idx = (ptr + k) % `NUM_PUSH;
      if (!found && req[idx]) begin
        result[idx] = 1'b1;
        found = 1'b1;
      end
    end
    return result;
  endfunction

  // --------------------
  // Stimulus and drivers
  // --------------------

  // Loads the file, checks every word and counts the transfers
  task automatic readStimulus();
    logic [31:0] word;
    bit ended;
    ended = 1'b0;
    $readmemh("bench/xbar_stimulus.txt", stimMem);
    for (int idx = 0; idx < stimDepth; idx++) begin
      word = stimMem[idx];
      if (!ended) begin
        if (word[31:28] == 4'hF) begin
          ended = 1'b1;
        end else if (word[31:28] == 4'h0) begin
          if (int'(word[27:24]) >= `NUM_PUSH)
            failRun("Stimulus entry names a push flow that does not exist");
          if (int'(word[23:20]) >= `NUM_POP)
            failRun("Stimulus entry names a pop flow that does not exist");
          if (word[15:12] != word[27:24])
            failRun("Stimulus data word does not carry its source number");
          totalEntries++;
        end else if (word[31:28] != 4'h1) begin
          failRun("Stimulus file holds a word with an unknown tag");
        end
      end
    end
    if (!ended)
      failRun("Stimulus file has no end marker");
  endtask

  task automatic applyReset();
    reset = 1'b1;
    pushValid = '0;
    popReady = '0;
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
  endtask

  // Ready is sampled at the falling edge, where the combinational logic has settled
  task automatic waitAccept(input int src);
    int cycles;
    bit seen;
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < acceptTimeout) begin
      @(negedge clk);
      seen = pushReady[src];
      cycles++;
    end
    if (!seen)
      failRun($sformatf("No transfer accepted within timeout on push flow %0d", src));
  endtask

  // Walks the file and pushes every entry of one source in the given phase
  task automatic pushFlow(input int src, input int phase);
    logic [31:0] word;
    int filePhase;
    int dest;
    xbarPkg::dataT data;
    filePhase = 0;
    for (int idx = 0; idx < stimDepth; idx++) begin
      word = stimMem[idx];
      if (word[31:28] == 4'hF)
        break;
      if (word[31:28] == 4'h1) begin
        filePhase = int'(word[3:0]);
      end else if (filePhase == phase && int'(word[27:24]) == src) begin
        dest = int'(word[23:20]);
        data = word[15:0];
        expQ[src*`NUM_POP+dest].push_back(data);
        pushValid[src] = 1'b1;
        pushData[src] = data;
        pushDestId[src] = xbarPkg::destIdT'(dest);
        waitAccept(src);
        @(posedge clk);
        #2;
      end
    end
    pushValid[src] = 1'b0;
  endtask

  // All sources run in parallel while popReady is either held high or randomized
  task automatic runPhase(input int phase, input bit randomPop);
    int cycles;
    logic [31:0] rnd;
    currentPhase = phase;
    flowsDone = 1'b0;
    cycles = 0;
    fork
      begin
        fork
          pushFlow(0, phase);
          pushFlow(1, phase);
          pushFlow(2, phase);
          pushFlow(3, phase);
        join
        flowsDone = 1'b1;
      end
      begin
        while (!flowsDone) begin
          rnd = nextRandom();
          popReady = randomPop ? xbarPkg::popMaskT'(rnd >> 24) : '1;
          cycles++;
          if (cycles > phaseLimit)
            failRun("Phase did not finish within the cycle limit");
          @(posedge clk);
          #2;
        end
        popReady = '1;
      end
    join
  endtask

  // --------------------
  // Monitor
  // --------------------

  always @(negedge clk) begin
    xbarPkg::pushMaskT reqMask;
    xbarPkg::pushMaskT observed;
    xbarPkg::popMaskT expValid;
    xbarPkg::dataT head;
    int src;
    int slot;
    int seq;
    int winner;
    int accepted;
    int pops;
    if (reset) begin
      for (int j = 0; j < `NUM_POP; j++)
        modelPtr[j] = 0;
      for (int s = 0; s < `NUM_PUSH*`NUM_POP; s++)
        lastSeq[s] = -1;
    end else begin
      accepted = $countones(pushValid & pushReady);
      pops = 0;
      expValid = '0;
      for (int j = 0; j < `NUM_POP; j++) begin
        for (int i = 0; i < `NUM_PUSH; i++)
          reqMask[i] = pushValid[i] && (pushDestId[i] == xbarPkg::destIdT'(j));
        expValid[j] = |reqMask;
        observed = pushReady & reqMask;
        if (popValid[j] && popReady[j]) begin
          pops++;
          checkGrant(expectedGrant(reqMask, modelPtr[j]), observed, "grant at pop flow");
          winner = 0;
          for (int i = 0; i < `NUM_PUSH; i++)
            if (observed[i]) winner = i;
          modelPtr[j] = (winner + 1) % `NUM_PUSH;
          // The top nibble names the source that pushed this word
          src = int'(popData[j][`DATA_WIDTH-1 -: 4]);
          if (src >= `NUM_PUSH)
            failRun("Pop flow delivered a word from an unknown source");
          slot = src * `NUM_POP + j;
          // A word that is not newer than the last one of its pair came out of order
          seq = int'(popData[j][`DATA_WIDTH-5:0]);
          if (seq <= lastSeq[slot]) begin
            $display("ERR %0t: sequence %0d after %0d on pop flow %0d", $time, seq,
                     lastSeq[slot], j);
            stopRun();
          end
          lastSeq[slot] = seq;
          if (expQ[slot].size() == 0)
            failRun("Pop flow delivered a word that was never pushed");
          head = expQ[slot].pop_front();
          checkData(head, popData[j], "pop data");
        end else if (popValid[j]) begin
          // Nobody aimed at a stalled output may see ready
          checkGrant('0, observed, "push ready under back-pressure");
        end
      end
      checkValid(expValid, popValid, "pop valid");
      checkCount(accepted, pops, "pushes accepted against pops in one cycle");
      pushCount += accepted;
      popCount += pops;
      // Distinct destinations must all pass in the same cycle
      if (currentPhase == 1 && pushValid != '0)
        checkGrant(pushValid, pushReady, "parallel push ready");
    end
  end

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    reset = 1'b1;
    pushValid = '0;
    pushData = '0;
    pushDestId = '0;
    popReady = '0;
    flowsDone = 1'b0;
    lcgState = 32'ha864_319a;
    readStimulus();
    applyReset();
    runPhase(1, 1'b0);
    // Round robin starts from a fresh pointer
    applyReset();
    runPhase(2, 1'b0);
    applyReset();
    runPhase(3, 1'b1);
    for (int s = 0; s < `NUM_PUSH*`NUM_POP; s++)
      checkCount(0, expQ[s].size(), "words left in an expected queue");
    checkCount(totalEntries, pushCount, "accepted pushes");
    checkCount(totalEntries, popCount, "completed pops");
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/xbar_stimulus.txt ====
// Each word holds tag, source, destination and a zero nibble, then the data word
// Tag 1 opens a phase with its number in the low digit and tag F ends the list
// Parallel phase with four distinct destinations in every cycle
1000_0001
0000_0001
0110_1001
0220_2001
0330_3001
0010_0002
0120_1002
0230_2002
0300_3002
0020_0003
0130_1003
0200_2003
0310_3003
// Round-robin phase with every source aimed at output 2
1000_0002
0020_0004
0120_1004
0220_2004
0320_3004
0020_0005
0120_1005
0220_2005
0320_3005
0020_0006
0120_1006
0220_2006
0320_3006
0020_0007
0120_1007
0220_2007
0320_3007
// Back-pressure phase with mixed and colliding destinations
1000_0003
0010_0008
0130_1008
0210_2008
0330_3008
0030_0009
0100_1009
0210_2009
0320_3009
0030_000A
0120_100A
0200_200A
0310_300A
0000_000B
0120_100B
0230_200B
0310_300B
F000_0000

// ==== list.f ====
+incdir+verilog
verilog/xbarPkg.sv
verilog/rrArbiter.sv
verilog/xbarCore.sv
verilog/flowXbarRr.sv
bench/flowXbarRr_assert.sv
bench/flowXbarRr_tb.sv

// ==== Makefile ====
# Verilator build and run of the crossbar testbench

sim:
	verilator --binary --timing --assert -f list.f --top-module flowXbarRr_tb --Mdir obj_dir -o simv
	./obj_dir/simv 2>&1 | tee sim.log
	@if grep -q "Testbench failed" sim.log || ! grep -q "Testbench passed" sim.log; then \
		echo "Simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
